// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = fun_fpusqr_tb
FILELIST = fun_fpusqr.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== fun_fpusqr.f ====
logic/fpu_sqrt_pkg.sv
logic/sqrt_operand_select.sv
logic/sqrt_root_core.sv
logic/fp_exception_report.sv
logic/fun_fpusqr.sv
verification/fun_fpusqr_tb.sv

// ==== logic/fp_exception_report.sv ====
`timescale 1ns/1ns

module fp_exception_report import fpu_sqrt_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         done,
  input  sqrt_result_t result,
  input  fp_flags_t    trap_en,
  output logic         ret_en,
  output sqrt_retire_t ret
);

  fp_flags_t trapped;
  ret_code_e code;

  assign trapped = result.flags & trap_en;

  // Invalid wins over inexact.
  always_comb begin
    if (trapped.invalid) begin
      code = RET_TRAP_INVALID;
    end else if (trapped.inexact) begin
      code = RET_TRAP_INEXACT;
    end else begin
      code = RET_OK;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ret_en <= 1'b0;
    end else begin
      ret_en <= done;
    end
  end

  always_ff @(posedge clk) begin
    if (done) begin
      ret.tag   <= result.tag;
      ret.value <= result.value;
      ret.flags <= result.flags;               // Unmasked.
      ret.code  <= code;
    end
  end

endmodule

// ==== logic/fpu_sqrt_pkg.sv ====
package fpu_sqrt_pkg;

  localparam int FWD_BUSES = 10;
  localparam int FP_WIDTH  = 32;
  localparam int TAG_WIDTH = 6;

  // IEEE 754 exception flags.
  typedef struct packed {
    logic invalid;
    logic div_zero;
    logic overflow;
    logic underflow;
    logic inexact;
  } fp_flags_t;

  typedef enum logic {
    SQRT_OP_SQRT = 1'b1,
    SQRT_OP_NOP  = 1'b0
  } sqrt_op_e;

  typedef enum logic [3:0] {
    SRC_FWD0 = 4'd0,
    SRC_FWD1,
    SRC_FWD2,
    SRC_FWD3,
    SRC_FWD4,
    SRC_FWD5,
    SRC_FWD6,
    SRC_FWD7,
    SRC_FWD8,
    SRC_FWD9,
    SRC_REG                        // Register-read port.
  } src_sel_e;

  typedef enum logic [1:0] {
    IDLE,
    UNPACK,
    ITERATE,
    ROUND
  } core_state_e;

  typedef enum logic [1:0] {
    RET_OK           = 2'd0,
    RET_TRAP_INVALID = 2'd1,
    RET_TRAP_INEXACT = 2'd2
  } ret_code_e;

  typedef struct packed {
    sqrt_op_e              op;
    logic [TAG_WIDTH-1:0]  tag;
    src_sel_e              src;
    logic [FP_WIDTH-1:0]   reg_operand;
  } sqrt_issue_t;

  typedef struct packed {
    logic [TAG_WIDTH-1:0]  tag;
    logic [FP_WIDTH-1:0]   value;
    fp_flags_t             flags;
  } sqrt_result_t;

  // Flags go out unmasked so retire can accrue them.
  typedef struct packed {
    logic [TAG_WIDTH-1:0]  tag;
    logic [FP_WIDTH-1:0]   value;
    fp_flags_t             flags;
    ret_code_e             code;
  } sqrt_retire_t;

endpackage

// ==== logic/fun_fpusqr.sv ====
`timescale 1ns/1ns

module fun_fpusqr import fpu_sqrt_pkg::*; #(
  parameter int FWD_BUSES = fpu_sqrt_pkg::FWD_BUSES,
  parameter int FP_WIDTH  = fpu_sqrt_pkg::FP_WIDTH,
  parameter int TAG_WIDTH = fpu_sqrt_pkg::TAG_WIDTH
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               issue_en,
  input  sqrt_issue_t                        issue,
  input  logic [FWD_BUSES-1:0][FP_WIDTH-1:0] fwd_bus,
  input  fp_flags_t                          trap_en,
  output logic                               busy,
  output logic                               ret_en,
  output sqrt_retire_t                       ret
);

  logic                 op_valid;
  logic [TAG_WIDTH-1:0] op_tag;
  logic [FP_WIDTH-1:0]  operand;
  logic                 done;
  sqrt_result_t         result;

  sqrt_operand_select #(
    .FWD_BUSES (FWD_BUSES),
    .FP_WIDTH  (FP_WIDTH),
    .TAG_WIDTH (TAG_WIDTH)
  ) u_operand_select (
    .clk      (clk),
    .rst_n    (rst_n),
    .issue_en (issue_en),
    .issue    (issue),
    .fwd_bus  (fwd_bus),
    .busy     (busy),
    .op_valid (op_valid),
    .op_tag   (op_tag),
    .operand  (operand)
  );

  sqrt_root_core #(
    .FP_WIDTH  (FP_WIDTH),
    .TAG_WIDTH (TAG_WIDTH)
  ) u_root_core (
    .clk      (clk),
    .rst_n    (rst_n),
    .op_valid (op_valid),
    .op_tag   (op_tag),
    .operand  (operand),
    .busy     (busy),
    .done     (done),
    .result   (result)
  );

  fp_exception_report u_exception_report (
    .clk     (clk),
    .rst_n   (rst_n),
    .done    (done),
    .result  (result),
    .trap_en (trap_en),
    .ret_en  (ret_en),
    .ret     (ret)
  );

endmodule

// ==== logic/sqrt_operand_select.sv ====
`timescale 1ns/1ns

module sqrt_operand_select import fpu_sqrt_pkg::*; #(
  parameter int FWD_BUSES = fpu_sqrt_pkg::FWD_BUSES,
  parameter int FP_WIDTH  = fpu_sqrt_pkg::FP_WIDTH,
  parameter int TAG_WIDTH = fpu_sqrt_pkg::TAG_WIDTH
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               issue_en,
  input  sqrt_issue_t                        issue,
  input  logic [FWD_BUSES-1:0][FP_WIDTH-1:0] fwd_bus,
  input  logic                               busy,
  output logic                               op_valid,
  output logic [TAG_WIDTH-1:0]               op_tag,
  output logic [FP_WIDTH-1:0]                operand
);

  logic [FP_WIDTH-1:0] sel_word;
  logic                take;

  // Bypass mux. Anything that is not a forwarding bus reads the register port.
  always_comb begin
    sel_word = issue.reg_operand;
    for (int i = 0; i < FWD_BUSES; i++) begin
      if (int'(issue.src) == i) begin
        sel_word = fwd_bus[i];
      end
    end
  end

  assign take = issue_en && !busy && (issue.op == SQRT_OP_SQRT); // NOPs and late issues vanish.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_valid <= 1'b0;
    end else begin
      op_valid <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      op_tag  <= issue.tag;
      operand <= sel_word;
    end
  end

endmodule

// ==== logic/sqrt_root_core.sv ====
`timescale 1ns/1ns

module sqrt_root_core import fpu_sqrt_pkg::*; #(
  parameter int FP_WIDTH  = fpu_sqrt_pkg::FP_WIDTH,
  parameter int TAG_WIDTH = fpu_sqrt_pkg::TAG_WIDTH
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 op_valid,
  input  logic [TAG_WIDTH-1:0] op_tag,
  input  logic [FP_WIDTH-1:0]  operand,
  output logic                 busy,
  output logic                 done,
  output sqrt_result_t         result
);

  localparam int                  ITERATIONS = 25; // 24 root bits and a round bit.
  localparam logic [FP_WIDTH-1:0] QNAN       = FP_WIDTH'(32'h7fc0_0000);

  core_state_e          state;
  logic [4:0]           iter_cnt;
  logic [TAG_WIDTH-1:0] tag_q;
  logic [FP_WIDTH-1:0]  word_q;
  logic                 special_q;
  logic [FP_WIDTH-1:0]  spec_word_q;
  fp_flags_t            spec_flags_q;
  logic [7:0]           exp_q;
  logic [49:0]          rad_q;
  logic [27:0]          rem_q;
  logic [24:0]          root_q;

  logic                 sign;
  logic [7:0]           exp_f;
  logic [22:0]          frac;
  logic                 spec_hit;
  logic [FP_WIDTH-1:0]  spec_word;
  fp_flags_t            spec_flags;
  logic [27:0]          rem_shift;
  logic [27:0]          trial;
  logic [27:0]          rem_next;
  logic [24:0]          root_next;
  logic                 sticky;
  logic                 round_up;
  logic [FP_WIDTH-1:0]  packed_word;
  fp_flags_t            round_flags;

  assign sign  = word_q[FP_WIDTH-1];
  assign exp_f = word_q[30:23];
  assign frac  = word_q[22:0];

  // Classification. Subnormals have a zero exponent and flush to a signed zero.
  always_comb begin
    spec_hit   = 1'b1;
    spec_word  = word_q;
    spec_flags = '0;
    if (exp_f == 8'hff && frac != '0) begin
      spec_word          = QNAN;
      spec_flags.invalid = ~frac[22];      // Only a signalling NaN.
    end else if (exp_f == 8'h00) begin
      spec_word = {sign, {(FP_WIDTH-1){1'b0}}};
    end else if (sign) begin
      spec_word          = QNAN;
      spec_flags.invalid = 1'b1;
    end else if (exp_f != 8'hff) begin
      spec_hit = 1'b0;                     // Positive normal, the real work.
    end
  end

  // One restoring step: bring down two radicand bits and try 4q+1.
  always_comb begin
    rem_shift = {rem_q[25:0], rad_q[49:48]};
    trial     = {1'b0, root_q, 2'b01};
    if (rem_shift >= trial) begin
      rem_next  = rem_shift - trial;
      root_next = {root_q[23:0], 1'b1};
    end else begin
      rem_next  = rem_shift;
      root_next = {root_q[23:0], 1'b0};
    end
  end

  // Round to nearest even. A carry out of the fraction bumps the exponent.
  always_comb begin
    sticky      = |rem_q;
    round_up    = root_q[0] & (sticky | root_q[1]);
    packed_word = {1'b0, exp_q, root_q[23:1]} + FP_WIDTH'(round_up);
    round_flags = '0;
    round_flags.inexact = root_q[0] | sticky;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      iter_cnt <= '0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (op_valid) state <= UNPACK;
        end
        UNPACK: begin
          iter_cnt <= '0;
          state    <= ITERATE;
        end
        ITERATE: begin
          iter_cnt <= iter_cnt + 5'd1;
          if (iter_cnt == 5'(ITERATIONS - 1)) state <= ROUND;
        end
        ROUND: begin
          done  <= 1'b1;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      IDLE: begin
        if (op_valid) begin
          tag_q  <= op_tag;
          word_q <= operand;
        end
      end
      UNPACK: begin
        special_q    <= spec_hit;
        spec_word_q  <= spec_word;
        spec_flags_q <= spec_flags;
        // Halved biased exponent, odd and even unbiased exponents alike.
        exp_q  <= 8'((9'(exp_f) + 9'd127) >> 1);
        // Even biased exponent means an odd unbiased one, so shift one more.
        rad_q  <= exp_f[0] ? {2'b01, frac, 25'b0} : {1'b1, frac, 26'b0};
        rem_q  <= '0;
        root_q <= '0;
      end
      ITERATE: begin
        rad_q  <= rad_q << 2;
        rem_q  <= rem_next;
        root_q <= root_next;
      end
      ROUND: begin
        result.tag <= tag_q;
        if (special_q) begin
          result.value <= spec_word_q;
          result.flags <= spec_flags_q;
        end else begin
          result.value <= packed_word;
          result.flags <= round_flags;
        end
      end
      default: ;
    endcase
  end

  assign busy = op_valid || (state != IDLE) || done;

endmodule

// ==== verification/fun_fpusqr_tb.sv ====
`timescale 1ns/1ns

module fun_fpusqr_tb import fpu_sqrt_pkg::*; ();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int LATENCY      = 29;
  localparam int TEST_CYCLES  = 40;  // Budget for one vector test.
  localparam int DROP_CYCLES  = 2 * LATENCY + 50;  // Budget for one dropped-issue test.

  logic                               clk;
  logic                               rst_n;
  logic                               issue_en;
  sqrt_issue_t                        issue;
  logic [FWD_BUSES-1:0][FP_WIDTH-1:0] fwd_bus;
  fp_flags_t                          trap_en;
  logic                               busy;
  logic                               ret_en;
  sqrt_retire_t                       ret;

  string                vec_name[$];
  logic [3:0]           vec_src[$];
  logic [31:0]          vec_operand[$];
  logic [4:0]           vec_trap[$];
  logic [31:0]          vec_result[$];
  logic [4:0]           vec_flags[$];
  logic [31:0]          lcg_state;
  logic [TAG_WIDTH-1:0] next_tag;
  int                   test_errors;
  int                   tests_run;
  int                   tests_failed;
  int                   limit;
  bit                   loaded;

  fun_fpusqr u_fun_fpusqr (
    .clk      (clk),
    .rst_n    (rst_n),
    .issue_en (issue_en),
    .issue    (issue),
    .fwd_bus  (fwd_bus),
    .trap_en  (trap_en),
    .busy     (busy),
    .ret_en   (ret_en),
    .ret      (ret)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Invalid trap first, then inexact trap.
  function automatic ret_code_e expected_code(input logic [4:0] flags, input logic [4:0] trap);
    if (flags[4] && trap[4]) return RET_TRAP_INVALID;
    if (flags[0] && trap[0]) return RET_TRAP_INEXACT;
    return RET_OK;
  endfunction

  task automatic check_value(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s %s: expected %h, actual %h", test, field, expected, actual);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string test);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %s passed", test);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", test, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic load_vectors();
    int          fd;
    int          code;
    int          c;
    string       name;
    logic [3:0]  src;
    logic [31:0] operand;
    logic [4:0]  trap;
    logic [31:0] result;
    logic [4:0]  flags;
    fd = $fopen("verification/fun_fpusqr_vectors.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open the vector file");
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", name);
      if (code != 1) break;
      if (name[0] == "#") begin
        c = $fgetc(fd);
        while (c != 10 && c != -1) c = $fgetc(fd);  // Skip the comment line.
      end else begin
        code = $fscanf(fd, "%h %h %h %h %h", src, operand, trap, result, flags);
        if (code != 5) begin
          $display("error: vector %s is incomplete", name);
          tests_failed++;
        end else begin
          vec_name.push_back(name);
          vec_src.push_back(src);
          vec_operand.push_back(operand);
          vec_trap.push_back(trap);
          vec_result.push_back(result);
          vec_flags.push_back(flags);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_vector(input int i);
    string                name;
    int                   cycles;
    logic [TAG_WIDTH-1:0] tag;
    name = vec_name[i];
    tag  = next_tag;
    next_tag++;
    for (int b = 0; b < FWD_BUSES; b++) begin
      fwd_bus[b] = (int'(vec_src[i]) == b) ? vec_operand[i] : lcg_next();
    end
    issue.reg_operand = (vec_src[i] == SRC_REG) ? vec_operand[i] : lcg_next();
    issue.op  = SQRT_OP_SQRT;
    issue.tag = tag;
    issue.src = src_sel_e'(vec_src[i]);
    trap_en   = vec_trap[i];
    issue_en  = 1'b1;
    @(negedge clk);
    issue_en = 1'b0;
    cycles   = 0;
    while (!ret_en && cycles < TEST_CYCLES) begin
      check_value(name, "busy", 32'd1, 32'(busy));
      @(negedge clk);
      cycles++;
    end
    if (!ret_en) begin
      $display("error %s: no retire within %0d cycles", name, TEST_CYCLES);
      test_errors++;
    end else begin
      check_value(name, "latency", 32'(LATENCY), 32'(cycles));
      check_value(name, "tag", 32'(tag), 32'(ret.tag));
      check_value(name, "result", vec_result[i], ret.value);
      check_value(name, "flags", 32'(vec_flags[i]), 32'(ret.flags));
      check_value(name, "retire code", 32'(expected_code(vec_flags[i], vec_trap[i])),
                  32'(ret.code));
      @(negedge clk);
      check_value(name, "ret_en after pulse", 32'd0, 32'(ret_en));
    end
    finish_test(name);
  endtask

  // A strobe while busy, or a NOP, must never retire.
  task automatic run_drop(input string name, input bit nop);
    int                   retires;
    int                   busy_cycles;
    logic [TAG_WIDTH-1:0] tag;
    tag = next_tag;
    next_tag += 2;
    issue.op          = nop ? SQRT_OP_NOP : SQRT_OP_SQRT;
    issue.tag         = tag;
    issue.src         = SRC_REG;
    issue.reg_operand = 32'h4080_0000;
    issue_en          = 1'b1;
    @(negedge clk);
    issue_en = 1'b0;
    retires     = 0;
    busy_cycles = 0;
    if (!nop) begin
      // Second strobe lands in the done cycle, the last one with busy high.
      repeat (LATENCY - 1) @(negedge clk);
      check_value(name, "busy at second issue", 32'd1, 32'(busy));
      issue.tag         = tag + 1'b1;
      issue.reg_operand = 32'h4110_0000;
      issue_en          = 1'b1;
      @(negedge clk);
      issue_en = 1'b0;
    end
    repeat (LATENCY + 40) begin
      if (busy) busy_cycles++;
      if (ret_en) begin
        retires++;
        check_value(name, "tag", 32'(tag), 32'(ret.tag));
      end
      @(negedge clk);
    end
    check_value(name, "retire count", nop ? 32'd0 : 32'd1, 32'(retires));
    if (nop) check_value(name, "busy cycles", 32'd0, 32'(busy_cycles));
    finish_test(name);
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    issue_en     = 1'b0;
    issue        = '0;
    fwd_bus      = '0;
    trap_en      = '0;
    lcg_state    = 32'h20234829;
    next_tag     = '0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    load_vectors();
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    check_value("reset", "busy in reset", 32'd0, 32'(busy));
    check_value("reset", "ret_en in reset", 32'd0, 32'(ret_en));
    rst_n = 1'b1;
    @(negedge clk);
    check_value("reset", "busy after reset", 32'd0, 32'(busy));
    check_value("reset", "ret_en after reset", 32'd0, 32'(ret_en));
    finish_test("reset");
    if (vec_name.size() == 0) begin
      $display("error: no test vectors were loaded");
      tests_failed++;
    end
    foreach (vec_name[i]) run_vector(i);
    run_drop("busy_drop", 1'b0);
    run_drop("nop_drop", 1'b1);
    $display("tests run %0d, passed %0d, failed %0d",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog sized from the vector count.
  initial begin
    wait (loaded);
    limit = RESET_CYCLES + 1 + vec_name.size() * TEST_CYCLES + 2 * DROP_CYCLES;
    #(limit * CLK_PERIOD);
    $display("error: timeout after %0d cycles, the tests did not finish", limit);
    $display("Regression failed");
    $finish;
  end

endmodule

// ==== verification/fun_fpusqr_vectors.txt ====
# name src operand trap_en result flags, all but the name in hex
# src 0 to 9 picks a forwarding bus and a the register port; flags are invalid..inexact
byp_fwd0 0 40400000 00 3fddb3d7 01
byp_fwd1 1 40400000 01 3fddb3d7 01
byp_fwd2 2 40400000 10 3fddb3d7 01
byp_fwd3 3 40400000 11 3fddb3d7 01
byp_fwd4 4 40400000 1f 3fddb3d7 01
byp_fwd5 5 40400000 0e 3fddb3d7 01
byp_fwd6 6 40400000 01 3fddb3d7 01
byp_fwd7 7 40400000 00 3fddb3d7 01
byp_fwd8 8 40400000 11 3fddb3d7 01
byp_fwd9 9 40400000 10 3fddb3d7 01
byp_reg a 40400000 01 3fddb3d7 01
sqrt_four a 40800000 1f 40000000 00
sqrt_two 0 40000000 01 3fb504f3 01
sqrt_quarter 1 3e800000 1f 3f000000 00
sqrt_1e30 2 7149f2ca 11 58635fa9 01
sqrt_nine 3 41100000 00 40400000 00
neg_four 4 c0800000 10 7fc00000 10
snan 5 7f800001 01 7fc00000 10
qnan 6 7fc00000 1f 7fc00000 00
neg_zero 7 80000000 1f 80000000 00
subnormal 8 00000001 1f 00000000 00
pos_inf 9 7f800000 1f 7f800000 00
